// ==== design/ddr3_pkg.sv ====
package ddr3_pkg;

	//////////////////////
	// Timing in controller clock cycles
	//////////////////////

	localparam int T_PWR       = 58; // Whole power-up window
	localparam int T_RST_REL   = 5;  // Memory reset release point
	localparam int T_CKE_ON    = 9;  // CKE rise point
	localparam int T_ZQ        = 2;  // ZQ calibration window
	localparam int T_MRD       = 4;  // Gap between mode register loads
	localparam int T_RCD       = 5;  // Activate to column command
	localparam int T_WL        = 4;  // Write latency
	localparam int T_CL        = 5;  // CAS latency
	localparam int T_RP        = 5;  // Precharge period
	localparam int BURST_BEATS = 4;  // BL4 style burst
	localparam int BEAT_W      = 16; // DQ width

	//////////////////////
	// Mode register values
	//////////////////////

	localparam logic [13:0] MR0_VAL = 14'h0518; // DLL reset, burst and CL setup
	localparam logic [13:0] MR1_VAL = 14'h0016; // DLL enable, drive strength
	localparam logic [13:0] MR2_VAL = 14'h0000; // CWL default
	localparam logic [13:0] MR3_VAL = 14'h0000; // MPR off
	localparam logic [13:0] ZQ_ADDR = 14'h0400; // A10 high selects long calibration

	//////////////////////
	// Widths
	//////////////////////

	typedef logic [26:0]       cpu_addr_t; // CPU byte address
	typedef logic [63:0]       cpu_word_t; // CPU data word
	typedef logic [BEAT_W-1:0] dq_beat_t;  // One beat on the DQ bus
	typedef logic [13:0]       mem_addr_t; // Row or column on A[13:0]
	typedef logic [2:0]        bank_t;     // BA[2:0]
	typedef logic [5:0]        tmr_t;      // Per-state timer

	// Controller FSM states
	typedef enum logic [3:0] {
		POWERUP,
		ZQ_CAL,
		CAL_DONE,
		MRLOAD,
		IDLE,
		ACT,
		WRITE,
		READ,
		WBURST,
		RBURST,
		AUTORP,
		DONE
	} ctrl_state_t;

	// One CPU request as held by the controller
	typedef struct packed {
		cpu_addr_t addr;
		cpu_word_t wr_data;
		logic      is_write; // 1 for write
	} cpu_req_t;

	// DDR3 command and control pins
	typedef struct packed {
		logic      rst_n;
		logic      cke;
		logic      odt;
		logic      cs_n;
		logic      ras_n;
		logic      cas_n;
		logic      we_n;
		bank_t     ba;
		mem_addr_t addr;
	} mem_cmd_t;

endpackage

// ==== design/ddr3_req_latch.sv ====
`timescale 1ns/1ps

module ddr3_req_latch import ddr3_pkg::*; (
	input  logic      i_cont_if_cpu,
	input  logic      i_cont_if_cpu_rst_n,
	input  logic      i_cpu_valid,
	input  logic      i_cpu_cmd,     // 1 means write
	input  cpu_addr_t i_cpu_addr,
	input  cpu_word_t i_cpu_wr_data,
	input  logic      i_idle,        // FSM sits in IDLE
	output logic      o_cpu_data_rdy,
	output cpu_req_t  o_req,
	output logic      o_start        // One-cycle kick to the FSM
);

	logic accept; // Handshake completes this edge

	// Ready drops as soon as a request is taken, FSM follows one cycle later
	assign o_cpu_data_rdy = i_idle & ~o_start;
	assign accept         = i_cpu_valid & o_cpu_data_rdy; // Valid without ready is dropped

	// Request payload
	always_ff @(posedge i_cont_if_cpu) begin
		if (accept) begin
			o_req.addr     <= i_cpu_addr;
			o_req.wr_data  <= i_cpu_wr_data;
			o_req.is_write <= i_cpu_cmd;
		end
	end

	// Start pulse
	always_ff @(posedge i_cont_if_cpu or negedge i_cont_if_cpu_rst_n) begin
		if (!i_cont_if_cpu_rst_n)
			o_start <= 1'b0;
		else
			o_start <= accept;
	end

	//////////////////////
	// Checks
	//////////////////////

	// FSM must leave IDLE right after a start, else ready would reopen for a second one
	a_one_start : assert property (@(posedge i_cont_if_cpu) disable iff (!i_cont_if_cpu_rst_n)
		o_start |=> !i_idle)
		else $error("start pulsed again without an IDLE in between");

endmodule

// ==== design/ddr3_cmd_fsm.sv ====
`timescale 1ns/1ps

module ddr3_cmd_fsm import ddr3_pkg::*; (
	input  logic        i_cont_if_cpu,
	input  logic        i_cont_if_cpu_rst_n,
	input  logic        i_start,
	input  cpu_req_t    i_req,
	output mem_cmd_t    o_mem_cmd,
	output ctrl_state_t o_state,
	output tmr_t        o_tmr,
	output logic        o_idle
);

	ctrl_state_t state, state_nxt;
	tmr_t        tmr;
	tmr_t        last_tmr; // Final timer value of the current state
	logic        tmr_done;
	mem_addr_t   row, col;
	bank_t       bank;
	logic        is_act, is_rd; // Decoded command flags for the checks

	// Address split
	assign row  = i_req.addr[26:13];
	assign bank = i_req.addr[12:10];
	assign col  = {4'b0000, i_req.addr[9:3], 3'b000}; // A10 stays low, no auto precharge

	//////////////////////
	// State timer
	//////////////////////

	always_comb begin
		unique case (state)
			POWERUP : last_tmr = tmr_t'(T_PWR - 1);
			ZQ_CAL  : last_tmr = tmr_t'(T_ZQ - 1);
			MRLOAD  : last_tmr = tmr_t'(4 * T_MRD - 1);
			ACT     : last_tmr = tmr_t'(T_RCD - 1);
			WRITE   : last_tmr = tmr_t'(T_WL - 1);
			READ    : last_tmr = tmr_t'(T_CL - 1);
			WBURST,
			RBURST  : last_tmr = tmr_t'(BURST_BEATS - 1);
			AUTORP  : last_tmr = tmr_t'(T_RP - 1);
			default : last_tmr = '0; // Single-cycle states and IDLE
		endcase
	end
	assign tmr_done = (tmr == last_tmr);

	always_comb begin
		state_nxt = state;
		unique case (state)
			POWERUP  : if (tmr_done) state_nxt = ZQ_CAL;
			ZQ_CAL   : if (tmr_done) state_nxt = CAL_DONE;
			CAL_DONE : state_nxt = MRLOAD;
			MRLOAD   : if (tmr_done) state_nxt = IDLE;
			IDLE     : if (i_start) state_nxt = ACT;
			ACT      : if (tmr_done) state_nxt = i_req.is_write ? WRITE : READ;
			WRITE    : if (tmr_done) state_nxt = WBURST;
			READ     : if (tmr_done) state_nxt = RBURST;
			WBURST,
			RBURST   : if (tmr_done) state_nxt = AUTORP;
			AUTORP   : if (tmr_done) state_nxt = DONE;
			DONE     : state_nxt = IDLE;
			default  : state_nxt = POWERUP;
		endcase
	end

	always_ff @(posedge i_cont_if_cpu or negedge i_cont_if_cpu_rst_n) begin
		if (!i_cont_if_cpu_rst_n) begin
			state <= POWERUP;
			tmr   <= '0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state)
				tmr <= '0;           // Fresh count per state
			else if (state != IDLE)
				tmr <= tmr + 1'b1;
		end
	end

	//////////////////////
	// Command decode
	//////////////////////

	always_comb begin
		o_mem_cmd = '{rst_n: 1'b1, cke: 1'b1, odt: 1'b0, cs_n: 1'b0, ras_n: 1'b1,
			cas_n: 1'b1, we_n: 1'b1, ba: '0, addr: '0}; // NOP
		unique case (state)
			POWERUP : begin
				o_mem_cmd.rst_n = (tmr >= tmr_t'(T_RST_REL));
				o_mem_cmd.cke   = (tmr >= tmr_t'(T_CKE_ON));
				o_mem_cmd.cs_n  = (tmr < tmr_t'(T_CKE_ON)); // Deselected until CKE is up
			end
			ZQ_CAL : if (tmr == '0) begin
				o_mem_cmd.we_n = 1'b0; // ZQCL
				o_mem_cmd.addr = ZQ_ADDR;
			end
			MRLOAD : if (tmr % T_MRD == 0) begin
				o_mem_cmd.ras_n = 1'b0; // MRS
				o_mem_cmd.cas_n = 1'b0;
				o_mem_cmd.we_n  = 1'b0;
				o_mem_cmd.ba    = bank_t'(3 - tmr / T_MRD); // MR3 first, MR0 last
				case (o_mem_cmd.ba)
					3'd3    : o_mem_cmd.addr = MR3_VAL;
					3'd2    : o_mem_cmd.addr = MR2_VAL;
					3'd1    : o_mem_cmd.addr = MR1_VAL;
					default : o_mem_cmd.addr = MR0_VAL;
				endcase
			end
			ACT : if (tmr == '0) begin
				o_mem_cmd.ras_n = 1'b0; // Open row
				o_mem_cmd.ba    = bank;
				o_mem_cmd.addr  = row;
			end
			WRITE : begin
				o_mem_cmd.odt = 1'b1; // Termination on for incoming write data
				if (tmr == '0) begin
					o_mem_cmd.cas_n = 1'b0;
					o_mem_cmd.we_n  = 1'b0;
					o_mem_cmd.ba    = bank;
					o_mem_cmd.addr  = col;
				end
			end
			READ : if (tmr == '0) begin
				o_mem_cmd.cas_n = 1'b0;
				o_mem_cmd.ba    = bank;
				o_mem_cmd.addr  = col;
			end
			WBURST : o_mem_cmd.odt = 1'b1;
			AUTORP : if (tmr == '0) begin
				o_mem_cmd.ras_n = 1'b0; // Precharge all
				o_mem_cmd.we_n  = 1'b0;
				o_mem_cmd.ba    = bank;
				o_mem_cmd.addr  = 14'h0400;
			end
			default : ; // NOP
		endcase
	end

	assign o_state = state;
	assign o_tmr   = tmr;
	assign o_idle  = (state == IDLE);

	//////////////////////
	// Checks
	//////////////////////

	assign is_act = !o_mem_cmd.cs_n && !o_mem_cmd.ras_n && o_mem_cmd.cas_n && o_mem_cmd.we_n;
	assign is_rd  = !o_mem_cmd.cs_n && o_mem_cmd.ras_n && !o_mem_cmd.cas_n && o_mem_cmd.we_n;

	a_act_one : assert property (@(posedge i_cont_if_cpu) disable iff (!i_cont_if_cpu_rst_n)
		is_act |=> o_mem_cmd.ras_n)
		else $error("activate held longer than one cycle");

	a_rcd : assert property (@(posedge i_cont_if_cpu) disable iff (!i_cont_if_cpu_rst_n)
		is_act |-> ##T_RCD (!o_mem_cmd.cas_n && o_mem_cmd.ras_n))
		else $error("column command not T_RCD after activate");

	// ODT stays off from the read command to the end of RBURST
	a_rd_odt : assert property (@(posedge i_cont_if_cpu) disable iff (!i_cont_if_cpu_rst_n)
		is_rd |-> !o_mem_cmd.odt [*(T_CL + BURST_BEATS)])
		else $error("ODT high during a read");

endmodule

// ==== design/ddr3_write_burst.sv ====
`timescale 1ns/1ps

module ddr3_write_burst import ddr3_pkg::*; (
	input  logic        i_cont_if_cpu,
	input  logic        i_cont_if_cpu_rst_n,
	input  ctrl_state_t i_state,
	input  tmr_t        i_tmr,
	input  cpu_word_t   i_wr_data,
	output dq_beat_t    o_dq,
	output logic        o_dq_oe
);

	logic       oe_nxt;  // Beat due next cycle
	logic [1:0] idx_nxt; // Which slice goes out next

	// Look one cycle ahead so the registered beat lines up with WBURST
	always_comb begin
		oe_nxt  = 1'b0;
		idx_nxt = '0;
		if (i_state == WRITE && i_tmr == tmr_t'(T_WL - 1)) begin
			oe_nxt = 1'b1; // Beat 0 at WBURST entry
		end else if (i_state == WBURST && i_tmr < tmr_t'(BURST_BEATS - 1)) begin
			oe_nxt  = 1'b1;
			idx_nxt = i_tmr[1:0] + 2'd1;
		end
	end

	always_ff @(posedge i_cont_if_cpu) begin
		if (oe_nxt)
			o_dq <= i_wr_data[idx_nxt * BEAT_W +: BEAT_W]; // Lowest slice first
	end

	always_ff @(posedge i_cont_if_cpu or negedge i_cont_if_cpu_rst_n) begin
		if (!i_cont_if_cpu_rst_n)
			o_dq_oe <= 1'b0;
		else
			o_dq_oe <= oe_nxt;
	end

	a_oe_len : assert property (@(posedge i_cont_if_cpu) disable iff (!i_cont_if_cpu_rst_n)
		$rose(o_dq_oe) |-> o_dq_oe [*BURST_BEATS] ##1 !o_dq_oe)
		else $error("write burst enable length wrong");

endmodule

// ==== design/ddr3_read_capture.sv ====
`timescale 1ns/1ps

module ddr3_read_capture import ddr3_pkg::*; (
	input  logic        i_cont_if_cpu,
	input  logic        i_cont_if_cpu_rst_n,
	input  ctrl_state_t i_state,
	input  tmr_t        i_tmr,
	input  dq_beat_t    i_dq,
	output cpu_word_t   o_cpu_rd_data,
	output logic        o_cpu_rd_data_valid
);

	logic beat_en;  // Memory drives a beat this cycle
	logic last_beat;

	assign beat_en   = (i_state == RBURST);
	assign last_beat = beat_en && (i_tmr == tmr_t'(BURST_BEATS - 1));

	//////////////////////
	// Beat assembly
	//////////////////////

	// Timer doubles as beat index, beat 0 into the low slice
	always_ff @(posedge i_cont_if_cpu) begin
		if (beat_en)
			o_cpu_rd_data[i_tmr[1:0] * BEAT_W +: BEAT_W] <= i_dq;
	end

	// Word complete once the last beat is in, flagged in first AUTORP cycle
	always_ff @(posedge i_cont_if_cpu or negedge i_cont_if_cpu_rst_n) begin
		if (!i_cont_if_cpu_rst_n)
			o_cpu_rd_data_valid <= 1'b0;
		else
			o_cpu_rd_data_valid <= last_beat;
	end

endmodule

// ==== design/ddr3_ctrl_top.sv ====
`timescale 1ns/1ps

module ddr3_ctrl_top import ddr3_pkg::*; (
	input  logic      i_cont_if_cpu,
	input  logic      i_cont_if_cpu_rst_n,
	// CPU side
	input  logic      i_cpu_valid,
	input  logic      i_cpu_cmd,
	input  cpu_addr_t i_cpu_addr,
	input  cpu_word_t i_cpu_wr_data,
	output logic      o_cpu_data_rdy,
	output cpu_word_t o_cpu_rd_data,
	output logic      o_cpu_rd_data_valid,
	// Memory side
	output mem_cmd_t  o_mem_cmd,
	output dq_beat_t  o_dq,
	output logic      o_dq_oe,
	input  dq_beat_t  i_dq
);

	cpu_req_t    req;   // Latched request
	logic        start;
	logic        idle;
	ctrl_state_t state;
	tmr_t        tmr;

	ddr3_req_latch u_req_latch (
		.i_cont_if_cpu       (i_cont_if_cpu),
		.i_cont_if_cpu_rst_n (i_cont_if_cpu_rst_n),
		.i_cpu_valid         (i_cpu_valid),
		.i_cpu_cmd           (i_cpu_cmd),
		.i_cpu_addr          (i_cpu_addr),
		.i_cpu_wr_data       (i_cpu_wr_data),
		.i_idle              (idle),
		.o_cpu_data_rdy      (o_cpu_data_rdy),
		.o_req               (req),
		.o_start             (start)
	);

	ddr3_cmd_fsm u_cmd_fsm (
		.i_cont_if_cpu       (i_cont_if_cpu),
		.i_cont_if_cpu_rst_n (i_cont_if_cpu_rst_n),
		.i_start             (start),
		.i_req               (req),
		.o_mem_cmd           (o_mem_cmd),
		.o_state             (state),
		.o_tmr               (tmr),
		.o_idle              (idle)
	);

	ddr3_write_burst u_write_burst (
		.i_cont_if_cpu       (i_cont_if_cpu),
		.i_cont_if_cpu_rst_n (i_cont_if_cpu_rst_n),
		.i_state             (state),
		.i_tmr               (tmr),
		.i_wr_data           (req.wr_data),
		.o_dq                (o_dq),
		.o_dq_oe             (o_dq_oe)
	);

	ddr3_read_capture u_read_capture (
		.i_cont_if_cpu       (i_cont_if_cpu),
		.i_cont_if_cpu_rst_n (i_cont_if_cpu_rst_n),
		.i_state             (state),
		.i_tmr               (tmr),
		.i_dq                (i_dq),
		.o_cpu_rd_data       (o_cpu_rd_data),
		.o_cpu_rd_data_valid (o_cpu_rd_data_valid)
	);

endmodule

// ==== test/ddr3_mem_model.sv ====
`timescale 1ns/1ps

module ddr3_mem_model import ddr3_pkg::*; (
	input  logic     i_cont_if_cpu,
	input  mem_cmd_t i_mem_cmd,
	input  dq_beat_t i_dq,    // Write beats from the controller
	input  logic     i_dq_oe,
	output dq_beat_t o_dq     // Read beats back to the controller
);

	logic [63:0] mem [logic [23:0]]; // Word store keyed by bank, row, column
	logic [13:0] open_row;
	logic [23:0] wr_key;
	logic [47:0] wr_buf;  // Lower three beats of the burst in progress
	logic [63:0] rd_word;
	int          wr_idx;
	int          rd_cnt;  // Cycles since read command, 0 when quiet

	initial begin
		o_dq     = '0;
		open_row = '0;
		wr_key   = '0;
		wr_buf   = '0;
		rd_word  = '0;
		wr_idx   = 0;
		rd_cnt   = 0;
	end

	always @(posedge i_cont_if_cpu) begin
		// Activate
		if (!i_mem_cmd.cs_n && !i_mem_cmd.ras_n && i_mem_cmd.cas_n && i_mem_cmd.we_n)
			open_row = i_mem_cmd.addr;
		// Write command
		if (!i_mem_cmd.cs_n && i_mem_cmd.ras_n && !i_mem_cmd.cas_n && !i_mem_cmd.we_n) begin
			wr_key = {i_mem_cmd.ba, open_row, i_mem_cmd.addr[9:3]};
			wr_idx = 0;
		end
		if (i_dq_oe) begin
			if (wr_idx == BURST_BEATS - 1)
				mem[wr_key] = {i_dq, wr_buf}; // Last beat completes the word
			else
				wr_buf[wr_idx * BEAT_W +: BEAT_W] = i_dq;
			wr_idx = wr_idx + 1;
		end
		// Beats go out from T_CL cycles after the read command
		if (rd_cnt >= T_CL - 1 && rd_cnt < T_CL - 1 + BURST_BEATS)
			o_dq <= rd_word[(rd_cnt - T_CL + 1) * BEAT_W +: BEAT_W];
		else
			o_dq <= '0;
		if (rd_cnt != 0)
			rd_cnt = (rd_cnt == T_CL - 1 + BURST_BEATS) ? 0 : rd_cnt + 1;
		// Read command
		if (!i_mem_cmd.cs_n && i_mem_cmd.ras_n && !i_mem_cmd.cas_n && i_mem_cmd.we_n) begin
			if (mem.exists({i_mem_cmd.ba, open_row, i_mem_cmd.addr[9:3]}))
				rd_word = mem[{i_mem_cmd.ba, open_row, i_mem_cmd.addr[9:3]}];
			else
				rd_word = '0; // Never written
			rd_cnt = 1;
		end
	end

endmodule

// ==== test/tb_ddr3_ctrl.sv ====
`timescale 1ns/1ps

module tb_ddr3_ctrl import ddr3_pkg::*; ();

	localparam int READY_AT  = T_PWR + T_ZQ + 1 + 4 * T_MRD; // 77 cycles after reset
	localparam int MR_START  = T_PWR + T_ZQ + 1;             // First mode-register load
	localparam int N_PAIRS   = 6;
	localparam int WD_CYCLES = 4 + READY_AT + 12 * 21 + 50;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      i_cpu_valid;
	logic      i_cpu_cmd;
	cpu_addr_t i_cpu_addr;
	cpu_word_t i_cpu_wr_data;
	logic      o_cpu_data_rdy;
	cpu_word_t o_cpu_rd_data;
	logic      o_cpu_rd_data_valid;
	mem_cmd_t  o_mem_cmd;
	dq_beat_t  o_dq;
	logic      o_dq_oe;
	dq_beat_t  i_dq;

	logic [31:0] lfsr;
	logic [63:0] shadow [logic [23:0]]; // Words written so far, by address[26:3]
	int          cyc;        // Cycles since reset release
	int          age;        // Cycles since the accepting edge
	logic        in_flight;
	cpu_addr_t   exp_addr;
	cpu_word_t   exp_data;
	logic        exp_write;

	ddr3_ctrl_top u_dut (
		.i_cont_if_cpu       (clk),
		.i_cont_if_cpu_rst_n (rst_n),
		.i_cpu_valid         (i_cpu_valid),
		.i_cpu_cmd           (i_cpu_cmd),
		.i_cpu_addr          (i_cpu_addr),
		.i_cpu_wr_data       (i_cpu_wr_data),
		.o_cpu_data_rdy      (o_cpu_data_rdy),
		.o_cpu_rd_data       (o_cpu_rd_data),
		.o_cpu_rd_data_valid (o_cpu_rd_data_valid),
		.o_mem_cmd           (o_mem_cmd),
		.o_dq                (o_dq),
		.o_dq_oe             (o_dq_oe),
		.i_dq                (i_dq)
	);

	ddr3_mem_model u_mem (
		.i_cont_if_cpu (clk),
		.i_mem_cmd     (o_mem_cmd),
		.i_dq          (o_dq),
		.i_dq_oe       (o_dq_oe),
		.o_dq          (i_dq)
	);

	initial begin
		forever #20 clk = ~clk; // 40 ns period
	end

	//////////////////////
	// Helpers
	//////////////////////

	task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("Errors found");
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$fatal(1);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[62:0], lfsr[0]}; // One step per bit
		end
	endtask

	// Per-cycle checks of one transaction, age 1 is the cycle after acceptance
	task automatic check_txn();
		int   col_age;
		int   bs;
		int   pre_age;
		int   done_age;
		logic is_act;
		logic is_col;
		logic is_pre;
		col_age  = 2 + T_RCD;
		bs       = col_age + (exp_write ? T_WL : T_CL); // First burst cycle
		pre_age  = bs + BURST_BEATS;
		done_age = pre_age + T_RP + 1;
		is_act = !o_mem_cmd.cs_n && !o_mem_cmd.ras_n && o_mem_cmd.cas_n && o_mem_cmd.we_n;
		is_col = !o_mem_cmd.cs_n && o_mem_cmd.ras_n && !o_mem_cmd.cas_n;
		is_pre = !o_mem_cmd.cs_n && !o_mem_cmd.ras_n && o_mem_cmd.cas_n && !o_mem_cmd.we_n;
		expect_eq("activate", age == 2, is_act);
		if (age == 2) begin
			expect_eq("act bank", exp_addr[12:10], o_mem_cmd.ba);
			expect_eq("act row", exp_addr[26:13], o_mem_cmd.addr);
		end
		expect_eq("column cmd", age == col_age, is_col);
		if (age == col_age) begin
			expect_eq("col we_n", !exp_write, o_mem_cmd.we_n);
			expect_eq("col bank", exp_addr[12:10], o_mem_cmd.ba);
			expect_eq("col addr", {4'b0000, exp_addr[9:3], 3'b000}, o_mem_cmd.addr);
		end
		if (!exp_write)
			expect_eq("read odt", 1'b0, o_mem_cmd.odt); // No termination on a read
		expect_eq("dq_oe", exp_write && age >= bs && age < bs + BURST_BEATS, o_dq_oe);
		if (o_dq_oe)
			expect_eq("write beat", exp_data[(age - bs) * BEAT_W +: BEAT_W], o_dq);
		expect_eq("precharge", age == pre_age, is_pre);
		if (age == pre_age)
			expect_eq("precharge A10", 1'b1, o_mem_cmd.addr[10]);
		expect_eq("rd_data_valid", !exp_write && age == pre_age, o_cpu_rd_data_valid);
		if (o_cpu_rd_data_valid)
			expect_eq("read data", shadow[exp_addr[26:3]], o_cpu_rd_data);
		expect_eq("ready", age == done_age, o_cpu_data_rdy);
		if (age == done_age)
			in_flight = 1'b0;
	endtask

	//////////////////////
	// Monitor
	//////////////////////

	// Outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			expect_eq("ready in reset", 1'b0, o_cpu_data_rdy);
			expect_eq("rst_n in reset", 1'b0, o_mem_cmd.rst_n);
			expect_eq("cke in reset", 1'b0, o_mem_cmd.cke);
		end else begin
			if (cyc < T_PWR) begin
				expect_eq("mem rst_n", cyc >= T_RST_REL, o_mem_cmd.rst_n);
				expect_eq("cke", cyc >= T_CKE_ON, o_mem_cmd.cke);
			end
			if (cyc <= READY_AT) begin
				expect_eq("init ready", cyc == READY_AT, o_cpu_data_rdy);
				expect_eq("init odt", 1'b0, o_mem_cmd.odt); // Termination off through init
			end
			if (cyc >= T_PWR && cyc < READY_AT) begin
				expect_eq("mode load", cyc >= MR_START && (cyc - MR_START) % T_MRD == 0,
					!o_mem_cmd.cs_n && !o_mem_cmd.ras_n && !o_mem_cmd.cas_n && !o_mem_cmd.we_n);
				if (cyc >= MR_START && (cyc - MR_START) % T_MRD == 0)
					expect_eq("mode bank", 3 - (cyc - MR_START) / T_MRD, o_mem_cmd.ba);
			end
			if (in_flight) begin
				age = age + 1;
				check_txn();
			end else if (cyc > READY_AT) begin
				expect_eq("idle activate", 1'b1, o_mem_cmd.ras_n); // Nothing issued while idle
				expect_eq("idle dq_oe", 1'b0, o_dq_oe);
				expect_eq("idle ready", 1'b1, o_cpu_data_rdy);
			end
			if (i_cpu_valid && o_cpu_data_rdy) begin // Taken at the next edge
				in_flight = 1'b1;
				age       = 0;
				exp_addr  = i_cpu_addr;
				exp_data  = i_cpu_wr_data;
				exp_write = i_cpu_cmd;
				if (i_cpu_cmd)
					shadow[i_cpu_addr[26:3]] = i_cpu_wr_data;
			end
			cyc = cyc + 1;
		end
	end

	//////////////////////
	// Stimulus
	//////////////////////

	task automatic send(input logic cmd, input cpu_addr_t addr, input cpu_word_t data);
		do @(negedge clk); while (!o_cpu_data_rdy);
		@(posedge clk);
		i_cpu_valid   <= 1'b1;
		i_cpu_cmd     <= cmd;
		i_cpu_addr    <= addr;
		i_cpu_wr_data <= data;
		@(posedge clk);   // Accepting edge
		i_cpu_valid <= 1'b0;
	endtask

	// Request while busy, must be dropped
	task automatic poke_busy(input cpu_addr_t addr);
		@(posedge clk);
		i_cpu_valid <= 1'b1;
		i_cpu_cmd   <= 1'b1;
		i_cpu_addr  <= ~addr;
		repeat (3) @(posedge clk);
		i_cpu_valid <= 1'b0;
	endtask

	initial begin
		logic [63:0] a;
		logic [63:0] d;
		lfsr          = 32'h5673_7d3a;
		cyc           = 0;
		age           = 0;
		in_flight     = 1'b0;
		rst_n         = 1'b0;
		i_cpu_valid   = 1'b0;
		i_cpu_cmd     = 1'b0;
		i_cpu_addr    = '0;
		i_cpu_wr_data = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int p = 0; p < N_PAIRS; p++) begin
			take_bits(27, a);
			take_bits(64, d);
			send(1'b1, a[26:0], d);
			poke_busy(a[26:0]);
			send(1'b0, a[26:0], '0); // Read back the same word
			poke_busy(a[26:0]);
		end
		do @(negedge clk); while (!o_cpu_data_rdy);
		@(posedge clk);
		$display("No errors");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Errors found");
		$display("timeout, the tests did not finish in %0d cycles", WD_CYCLES);
		$fatal(1);
	end

endmodule

// ==== list.f ====
design/ddr3_pkg.sv
design/ddr3_req_latch.sv
design/ddr3_cmd_fsm.sv
design/ddr3_write_burst.sv
design/ddr3_read_capture.sv
design/ddr3_ctrl_top.sv
test/ddr3_mem_model.sv
test/tb_ddr3_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DDR3 controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module tb_ddr3_ctrl \
	-f list.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
	exit 0
else
	exit 1
fi
